//--- tk_pkg.sv
// Shared types, register map and fixed constants for the control core
// Imported by the interface, the RTL blocks and the testbench
package tk_pkg;

  // --------------------
  // Types
  // --------------------
  typedef logic [31:0] word_t;
  typedef logic [7:0]  reg_addr_t;
  typedef logic [14:0] rand_addr_t;

  // Red in bit 2, green in bit 1, blue in bit 0
  typedef logic [2:0]  led_t;

  // --------------------
  // Register map
  // --------------------
  localparam reg_addr_t addr_name0         = 8'h00;
  localparam reg_addr_t addr_name1         = 8'h01;
  localparam reg_addr_t addr_version       = 8'h02;
  localparam reg_addr_t addr_switch_app    = 8'h08;
  localparam reg_addr_t addr_led           = 8'h09;
  localparam reg_addr_t addr_gpio          = 8'h0a;
  localparam reg_addr_t addr_app_start     = 8'h0c;
  localparam reg_addr_t addr_app_size      = 8'h0d;
  localparam reg_addr_t addr_hash          = 8'h10;
  localparam reg_addr_t addr_cdi_first     = 8'h20;
  localparam reg_addr_t addr_cdi_last      = 8'h27;
  localparam reg_addr_t addr_udi_first     = 8'h30;
  localparam reg_addr_t addr_udi_last      = 8'h31;
  localparam reg_addr_t addr_ram_addr_rand = 8'h40;
  localparam reg_addr_t addr_ram_data_rand = 8'h41;
  localparam reg_addr_t addr_mon_ctrl      = 8'h60;
  localparam reg_addr_t addr_mon_first     = 8'h61;
  localparam reg_addr_t addr_mon_last      = 8'h62;

  // Identification, ASCII "tk1 " and "mkdf"
  localparam word_t core_name0   = 32'h746b3120;
  localparam word_t core_name1   = 32'h6d6b6466;
  localparam word_t core_version = 32'h00000005;

  // Firmware RAM window, no instruction fetch allowed here
  localparam word_t fw_ram_first = 32'hd0000000;
  localparam word_t fw_ram_last  = 32'hd00007ff;

  // Green and blue on
  localparam led_t led_reset_value = 3'b011;

endpackage

//--- tk_bus_if.sv
// Register bus between the top level and the register block
// Single cycle access, ready follows cs
`timescale 1ns/1ps

interface tk_bus_if;
  import tk_pkg::*;

  logic      cs;
  logic      we;
  reg_addr_t address;
  word_t     write_data;
  word_t     read_data;
  logic      ready;

  // Driving side
  modport master (output cs, output we, output address, output write_data,
                  input read_data, input ready);

  // Register block side
  modport slave (input cs, input we, input address, input write_data,
                 output read_data, output ready);

endinterface

//--- udi_rom.sv
// Unique device identifier, two fixed words
// Selected by the low bit of the register address
`timescale 1ns/1ps

module udi_rom (
  input  logic          udi_index,
  output tk_pkg::word_t udi_data
);

  always_comb begin
    case (udi_index)
      1'b0: udi_data = 32'h00010203;
      1'b1: udi_data = 32'h04050607;
      default: udi_data = '0;
    endcase
  end

endmodule

//--- tk_reg_api.sv
// Register block of the control core
// Decodes bus accesses, holds the configuration registers and the CDI store,
// applies the firmware and monitor locks and builds the read data
`timescale 1ns/1ps

module tk_reg_api (
  input  logic               clk,
  input  logic               reset_n,
  tk_bus_if.slave            bus,
  input  logic               gpio1,
  input  logic               gpio2,
  output logic               gpio3,
  output logic               gpio4,
  output logic               fw_app_mode,
  output tk_pkg::led_t       led_value,
  output tk_pkg::rand_addr_t ram_addr_rand,
  output tk_pkg::word_t      ram_data_rand,
  output logic               mon_en,
  output tk_pkg::word_t      mon_first,
  output tk_pkg::word_t      mon_last
);
  import tk_pkg::*;

  logic [1:0] gpio1_sync;
  logic [1:0] gpio2_sync;
  word_t      app_start_reg;
  word_t      app_size_reg;
  word_t      hash_addr_reg;
  word_t      cdi_mem [0:7];
  word_t      udi_data;
  logic       udi_index;
  logic       wr;
  logic       rd;
  logic       cdi_hit;
  logic       udi_hit;

  assign wr        = bus.cs & bus.we;
  assign rd        = bus.cs & ~bus.we;
  assign bus.ready = bus.cs;

  assign cdi_hit = (bus.address >= addr_cdi_first) && (bus.address <= addr_cdi_last);
  assign udi_hit = (bus.address >= addr_udi_first) && (bus.address <= addr_udi_last);

  assign udi_index = bus.address[0];

  udi_rom u_udi_rom (
    .udi_index (udi_index),
    .udi_data  (udi_data)
  );

  // --------------------
  // Control registers
  // --------------------
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      fw_app_mode   <= 1'b0;
      mon_en        <= 1'b0;
      led_value     <= led_reset_value;
      gpio1_sync    <= '0;
      gpio2_sync    <= '0;
      gpio3         <= 1'b0;
      gpio4         <= 1'b0;
      app_start_reg <= '0;
      app_size_reg  <= '0;
      hash_addr_reg <= '0;
      ram_addr_rand <= '0;
      ram_data_rand <= '0;
    end else begin
      // Two flop synchronizers on the input pins
      gpio1_sync <= {gpio1_sync[0], gpio1};
      gpio2_sync <= {gpio2_sync[0], gpio2};

      if (wr) begin
        case (bus.address)
          // Sticky until reset
          addr_switch_app: fw_app_mode <= 1'b1;
          addr_mon_ctrl:   mon_en <= 1'b1;
          addr_led:        led_value <= bus.write_data[2:0];
          addr_gpio: begin
            gpio3 <= bus.write_data[2];
            gpio4 <= bus.write_data[3];
          end
          addr_app_start: if (!fw_app_mode) app_start_reg <= bus.write_data;
          addr_app_size:  if (!fw_app_mode) app_size_reg <= bus.write_data;
          addr_hash:      if (!fw_app_mode) hash_addr_reg <= bus.write_data;
          addr_ram_addr_rand: if (!fw_app_mode) ram_addr_rand <= bus.write_data[14:0];
          addr_ram_data_rand: if (!fw_app_mode) ram_data_rand <= bus.write_data;
          default: ;
        endcase
      end
    end
  end

  // CDI store and monitor window bounds
  always_ff @(posedge clk) begin
    if (wr && cdi_hit && !fw_app_mode) begin
      cdi_mem[bus.address[2:0]] <= bus.write_data;
    end
    if (wr && (bus.address == addr_mon_first) && !mon_en) begin
      mon_first <= bus.write_data;
    end
    if (wr && (bus.address == addr_mon_last) && !mon_en) begin
      mon_last <= bus.write_data;
    end
  end

  // --------------------
  // Read path
  // --------------------
  always_comb begin
    bus.read_data = '0;
    if (rd) begin
      case (bus.address)
        addr_name0:      bus.read_data = core_name0;
        addr_name1:      bus.read_data = core_name1;
        addr_version:    bus.read_data = core_version;
        addr_switch_app: bus.read_data = {32{fw_app_mode}};
        addr_led:        bus.read_data = {29'h0, led_value};
        addr_gpio:       bus.read_data = {28'h0, gpio4, gpio3, gpio2_sync[1], gpio1_sync[1]};
        addr_app_start:  bus.read_data = app_start_reg;
        addr_app_size:   bus.read_data = app_size_reg;
        addr_hash:       bus.read_data = hash_addr_reg;
        default: begin
          if (cdi_hit) begin
            bus.read_data = cdi_mem[bus.address[2:0]];
          end else if (udi_hit && !fw_app_mode) begin
            // UDI hidden from the application
            bus.read_data = udi_data;
          end
        end
      endcase
    end
  end

endmodule

//--- tk_sec_monitor.sv
// Security monitor on the CPU memory interface
// Flags accesses beyond physical RAM and instruction fetches from
// firmware RAM or the enabled execution window, force_trap is sticky
`timescale 1ns/1ps

module tk_sec_monitor (
  input  logic          clk,
  input  logic          reset_n,
  input  tk_pkg::word_t cpu_addr,
  input  logic          cpu_instr,
  input  logic          cpu_valid,
  input  logic          mon_en,
  input  tk_pkg::word_t mon_first,
  input  tk_pkg::word_t mon_last,
  output logic          force_trap
);
  import tk_pkg::*;

  logic ram_oob;
  logic fw_fetch;
  logic mon_fetch;
  logic violation;

  // RAM decodes at 0x4xxxxxxx, only 128 KiB populated
  assign ram_oob = (cpu_addr[31:30] == 2'b01) && (|cpu_addr[29:17]);

  assign fw_fetch = cpu_instr && (cpu_addr >= fw_ram_first) && (cpu_addr <= fw_ram_last);

  // Data only window, set up by firmware
  assign mon_fetch = cpu_instr && mon_en &&
                     (cpu_addr >= mon_first) && (cpu_addr <= mon_last);

  assign violation = cpu_valid && (ram_oob || fw_fetch || mon_fetch);

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      force_trap <= 1'b0;
    end else if (violation) begin
      force_trap <= 1'b1;
    end
  end

endmodule

//--- tk_led_ctrl.sv
// RGB LED control
// Shows the software LED value, or a slow red blink while the CPU is trapped
`timescale 1ns/1ps

module tk_led_ctrl #(
  parameter int blink_width = 24
) (
  input  logic         clk,
  input  logic         reset_n,
  input  logic         cpu_trap,
  input  tk_pkg::led_t led_value,
  output logic         led_r,
  output logic         led_g,
  output logic         led_b
);
  import tk_pkg::*;

  localparam led_t red_only = 3'b100;

  logic [blink_width-1:0] blink_ctr;
  led_t                   trap_led;
  led_t                   muxed_led;

  // Free running, red flips on every wrap
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      blink_ctr <= '0;
      trap_led  <= '0;
    end else begin
      blink_ctr <= blink_ctr + 1'b1;
      if (blink_ctr == '0) begin
        trap_led <= trap_led ^ red_only;
      end
    end
  end

  assign muxed_led = cpu_trap ? trap_led : led_value;

  assign led_r = muxed_led[2];
  assign led_g = muxed_led[1];
  assign led_b = muxed_led[0];

endmodule

//--- tk_ctrl_top.sv
// Top level of the control core
// Loads the plain bus ports into the bus interface and connects the
// register block, the security monitor and the LED control
`timescale 1ns/1ps

module tk_ctrl_top #(
  parameter int blink_width = 24
) (
  input  logic               clk,
  input  logic               reset_n,
  input  logic               cs,
  input  logic               we,
  input  tk_pkg::reg_addr_t  address,
  input  tk_pkg::word_t      write_data,
  output tk_pkg::word_t      read_data,
  output logic               ready,
  input  logic               cpu_trap,
  input  tk_pkg::word_t      cpu_addr,
  input  logic               cpu_instr,
  input  logic               cpu_valid,
  output logic               force_trap,
  output logic               fw_app_mode,
  output tk_pkg::rand_addr_t ram_addr_rand,
  output tk_pkg::word_t      ram_data_rand,
  output logic               led_r,
  output logic               led_g,
  output logic               led_b,
  input  logic               gpio1,
  input  logic               gpio2,
  output logic               gpio3,
  output logic               gpio4
);
  import tk_pkg::*;

  led_t  led_value;
  logic  mon_en;
  word_t mon_first;
  word_t mon_last;

  tk_bus_if bus0 ();

  // --------------------
  // Bus bundling
  // --------------------
  assign bus0.cs         = cs;
  assign bus0.we         = we;
  assign bus0.address    = address;
  assign bus0.write_data = write_data;
  assign read_data       = bus0.read_data;
  assign ready           = bus0.ready;

  tk_reg_api u_reg_api (
    .clk           (clk),
    .reset_n       (reset_n),
    .bus           (bus0.slave),
    .gpio1         (gpio1),
    .gpio2         (gpio2),
    .gpio3         (gpio3),
    .gpio4         (gpio4),
    .fw_app_mode   (fw_app_mode),
    .led_value     (led_value),
    .ram_addr_rand (ram_addr_rand),
    .ram_data_rand (ram_data_rand),
    .mon_en        (mon_en),
    .mon_first     (mon_first),
    .mon_last      (mon_last)
  );

  tk_sec_monitor u_sec_monitor (
    .clk        (clk),
    .reset_n    (reset_n),
    .cpu_addr   (cpu_addr),
    .cpu_instr  (cpu_instr),
    .cpu_valid  (cpu_valid),
    .mon_en     (mon_en),
    .mon_first  (mon_first),
    .mon_last   (mon_last),
    .force_trap (force_trap)
  );

  tk_led_ctrl #(
    .blink_width (blink_width)
  ) u_led_ctrl (
    .clk       (clk),
    .reset_n   (reset_n),
    .cpu_trap  (cpu_trap),
    .led_value (led_value),
    .led_r     (led_r),
    .led_g     (led_g),
    .led_b     (led_b)
  );

endmodule

//--- tb_tk_ctrl.sv
// Testbench for the control core
// Replays the operations listed in tk_stimulus.txt against the DUT and
// checks bus reads, ready and the status, scrambling, GPIO and LED pins
`timescale 1ns/1ps

module tb_tk_ctrl;
  import tk_pkg::*;

  localparam int    clk_period    = 40;
  localparam int    drive_delay   = 2;
  localparam int    cycles_per_op = 200;
  localparam string stim_file     = "tk_stimulus.txt";

  logic       clk;
  logic       reset_n;
  logic       cs;
  logic       we;
  reg_addr_t  address;
  word_t      write_data;
  word_t      read_data;
  logic       ready;
  logic       cpu_trap;
  word_t      cpu_addr;
  logic       cpu_instr;
  logic       cpu_valid;
  logic       force_trap;
  logic       fw_app_mode;
  rand_addr_t ram_addr_rand;
  word_t      ram_data_rand;
  logic       led_r;
  logic       led_g;
  logic       led_b;
  logic       gpio1;
  logic       gpio2;
  logic       gpio3;
  logic       gpio4;

  int op_count;
  int fail_count;

  tk_ctrl_top #(
    .blink_width (4)
  ) dut0 (
    .clk           (clk),
    .reset_n       (reset_n),
    .cs            (cs),
    .we            (we),
    .address       (address),
    .write_data    (write_data),
    .read_data     (read_data),
    .ready         (ready),
    .cpu_trap      (cpu_trap),
    .cpu_addr      (cpu_addr),
    .cpu_instr     (cpu_instr),
    .cpu_valid     (cpu_valid),
    .force_trap    (force_trap),
    .fw_app_mode   (fw_app_mode),
    .ram_addr_rand (ram_addr_rand),
    .ram_data_rand (ram_data_rand),
    .led_r         (led_r),
    .led_g         (led_g),
    .led_b         (led_b),
    .gpio1         (gpio1),
    .gpio2         (gpio2),
    .gpio3         (gpio3),
    .gpio4         (gpio4)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  // --------------------
  // Checking helpers
  // --------------------
  task automatic fail_run(input string reason);
    fail_count++;
    $display("%s", reason);
    $display("Test FAILED");
    $fatal(1, "Stopped at the first error");
  endtask

  task automatic check_value(input string name, input word_t got, input word_t exp);
    assert (got === exp) else begin
      fail_run($sformatf("Mismatch at %0d ns: %s is %h, expected %h", $time, name, got, exp));
    end
  endtask

  task automatic expect_args(input int got, input int need, input logic [127:0] op);
    assert (got == need) else begin
      fail_run($sformatf("Malformed stimulus line for operation %0s", op));
    end
  endtask

  // Inputs change a short delay after the rising edge
  task automatic to_drive_point();
    @(posedge clk);
    #drive_delay;
  endtask

  // --------------------
  // Operations
  // --------------------
  task automatic apply_reset();
    reset_n   = 1'b0;
    cs        = 1'b0;
    we        = 1'b0;
    cpu_valid = 1'b0;
    repeat (5) @(posedge clk);
    #drive_delay;
    reset_n = 1'b1;
  endtask

  task automatic bus_write(input reg_addr_t addr, input word_t data);
    cs         = 1'b1;
    we         = 1'b1;
    address    = addr;
    write_data = data;
    @(negedge clk);
    check_value("ready", {31'h0, ready}, 32'h1);
    check_value("read_data", read_data, 32'h0);
    to_drive_point();
    cs = 1'b0;
    we = 1'b0;
  endtask

  task automatic bus_read(input reg_addr_t addr, input word_t exp);
    cs      = 1'b1;
    we      = 1'b0;
    address = addr;
    @(negedge clk);
    check_value("ready", {31'h0, ready}, 32'h1);
    check_value($sformatf("read_data[%h]", addr), read_data, exp);
    to_drive_point();
    cs = 1'b0;
  endtask

  task automatic cpu_access(input word_t addr, input logic instr, input logic exp_trap);
    cpu_addr  = addr;
    cpu_instr = instr;
    cpu_valid = 1'b1;
    to_drive_point();
    cpu_valid = 1'b0;
    @(negedge clk);
    check_value("force_trap", {31'h0, force_trap}, {31'h0, exp_trap});
    to_drive_point();
  endtask

  // Two synchronizer stages before the register sees the pins
  // The read that follows in the file comes with no idle gap
  task automatic drive_gpio(input logic g1, input logic g2);
    logic [1:0] old_levels;
    old_levels = {gpio2, gpio1};
    gpio1      = g1;
    gpio2      = g2;
    to_drive_point();
    // One edge later the register still shows the old levels
    cs      = 1'b1;
    we      = 1'b0;
    address = addr_gpio;
    @(negedge clk);
    check_value("ready", {31'h0, ready}, 32'h1);
    check_value("read_data[0a] bits 1:0", {30'h0, read_data[1:0]}, {30'h0, old_levels});
    to_drive_point();
    cs = 1'b0;
  endtask

  task automatic drive_trap(input logic level);
    logic red_start;
    logic toggled;
    cpu_trap = level;
    if (level) begin
      @(negedge clk);
      red_start = led_r;
      toggled   = 1'b0;
      for (int i = 0; i < 32 && !toggled; i++) begin
        check_value("led_g", {31'h0, led_g}, 32'h0);
        check_value("led_b", {31'h0, led_b}, 32'h0);
        @(negedge clk);
        toggled = (led_r != red_start);
      end
      assert (toggled) else begin
        fail_run("Red LED did not toggle within 32 cycles while cpu_trap was high");
      end
    end
    to_drive_point();
  endtask

  task automatic check_pin(input logic [127:0] sig_name, input word_t exp);
    word_t got;
    logic  known;
    known = 1'b1;
    got   = '0;
    @(negedge clk);
    case (sig_name)
      "fw_app_mode":   got = {31'h0, fw_app_mode};
      "force_trap":    got = {31'h0, force_trap};
      "gpio_out":      got = {30'h0, gpio4, gpio3};
      "leds":          got = {29'h0, led_r, led_g, led_b};
      "ram_addr_rand": got = {17'h0, ram_addr_rand};
      "ram_data_rand": got = ram_data_rand;
      default:         known = 1'b0;
    endcase
    if (known) begin
      check_value($sformatf("%0s", sig_name), got, exp);
    end else begin
      fail_run($sformatf("Unknown signal %0s in the stimulus file", sig_name));
    end
    to_drive_point();
  endtask

  // First pass over the file, sizes the watchdog
  task automatic count_ops();
    int           fd;
    logic [127:0] token;
    logic [1023:0] rest;
    fd = $fopen(stim_file, "r");
    if (fd == 0) begin
      fail_run("Cannot open the stimulus file");
    end
    while ($fscanf(fd, "%s", token) == 1) begin
      void'($fgets(rest, fd));
      if (token != "#") begin
        op_count++;
      end
    end
    $fclose(fd);
  endtask

  initial begin
    wait (op_count > 0);
    repeat ((op_count + 1) * cycles_per_op) @(posedge clk);
    fail_run("Timeout, the stimulus file did not finish in time");
  end

  // --------------------
  // Main sequence
  // --------------------
  initial begin
    int            fd;
    int            nargs;
    logic [127:0]  op;
    logic [127:0]  sig_name;
    logic [1023:0] rest;
    word_t         arg_a;
    word_t         arg_b;
    word_t         arg_c;
    reset_n    = 1'b0;
    cs         = 1'b0;
    we         = 1'b0;
    address    = '0;
    write_data = '0;
    cpu_trap   = 1'b0;
    cpu_addr   = '0;
    cpu_instr  = 1'b0;
    cpu_valid  = 1'b0;
    gpio1      = 1'b0;
    gpio2      = 1'b0;
    op_count   = 0;
    fail_count = 0;
    void'($urandom(25));
    count_ops();
    fd = $fopen(stim_file, "r");
    if (fd == 0) begin
      fail_run("Cannot open the stimulus file");
    end
    apply_reset();
    while ($fscanf(fd, "%s", op) == 1) begin
      if (op == "#") begin
        void'($fgets(rest, fd));
      end else begin
        case (op)
          "W": begin
            nargs = $fscanf(fd, "%h %h", arg_a, arg_b);
            expect_args(nargs, 2, op);
            bus_write(arg_a[7:0], arg_b);
          end
          "R": begin
            nargs = $fscanf(fd, "%h %h", arg_a, arg_b);
            expect_args(nargs, 2, op);
            bus_read(arg_a[7:0], arg_b);
          end
          "C": begin
            nargs = $fscanf(fd, "%h %h %h", arg_a, arg_b, arg_c);
            expect_args(nargs, 3, op);
            cpu_access(arg_a, arg_b[0], arg_c[0]);
          end
          "G": begin
            nargs = $fscanf(fd, "%h %h", arg_a, arg_b);
            expect_args(nargs, 2, op);
            drive_gpio(arg_a[0], arg_b[0]);
          end
          "T": begin
            nargs = $fscanf(fd, "%h", arg_a);
            expect_args(nargs, 1, op);
            drive_trap(arg_a[0]);
          end
          "P": begin
            nargs = $fscanf(fd, "%s %h", sig_name, arg_b);
            expect_args(nargs, 2, op);
            check_pin(sig_name, arg_b);
          end
          "X": apply_reset();
          default: fail_run($sformatf("Unknown operation %0s in the stimulus file", op));
        endcase
        // Random idle gap between operations
        if (op != "G") begin
          repeat ($urandom_range(0, 2)) to_drive_point();
        end
      end
    end
    $fclose(fd);
    if (fail_count == 0) begin
      $display("Test OK");
      $finish;
    end else begin
      $display("Test FAILED");
      $fatal(1, "Checks failed");
    end
  end

endmodule

//--- tk_stimulus.txt
# Columns: op arg1 arg2 arg3, all values in hex
# W addr data | R addr expected | C cpu_addr instr force_trap | G gpio1 gpio2 | T cpu_trap | X reset | P signal expected
# Identification and unmapped reads
R 00 746b3120
R 01 6d6b6466
R 02 00000005
R 03 00000000
R 7f 00000000
# State after reset
P leds 3
P fw_app_mode 0
P force_trap 0
P gpio_out 0
P ram_addr_rand 0
P ram_data_rand 0
# Write and read back in firmware mode
W 09 00000005
R 09 00000005
P leds 5
W 0a 0000000c
R 0a 0000000c
P gpio_out 3
W 0c 40000100
R 0c 40000100
W 0d 00001000
R 0d 00001000
W 10 40002000
R 10 40002000
W 20 11111111
W 21 22222222
W 22 33333333
W 23 44444444
W 24 55555555
W 25 66666666
W 26 77777777
W 27 88888888
R 20 11111111
R 21 22222222
R 22 33333333
R 23 44444444
R 24 55555555
R 25 66666666
R 26 77777777
R 27 88888888
W 40 00001234
P ram_addr_rand 1234
W 41 cafef00d
P ram_data_rand cafef00d
R 30 00010203
R 31 04050607
# Switch to application mode, locked registers keep their values
W 08 00000001
P fw_app_mode 1
W 0c 00000000
R 0c 40000100
W 0d 00000000
R 0d 00001000
W 10 00000000
R 10 40002000
W 23 00000000
R 23 44444444
W 40 00000000
P ram_addr_rand 1234
W 41 00000000
P ram_data_rand cafef00d
R 30 00000000
R 31 00000000
W 09 00000006
R 09 00000006
W 0a 00000004
P gpio_out 1
# GPIO inputs
G 1 0
R 0a 00000005
G 0 1
R 0a 00000006
G 1 1
R 0a 00000007
# RAM bound check, force_trap is sticky
C 4001fffc 0 0
C 40020000 0 1
C 00000000 0 1
# Trap blink, then back to the software LED value
T 1
T 0
P leds 6
# Instruction fetch from firmware RAM
X
P leds 3
C d0000400 0 0
C d0000400 1 1
# Execution monitor window, bounds locked once enabled
X
W 61 40001000
W 62 40001fff
W 60 00000001
W 61 40000000
C 40000800 1 0
C 40001800 0 0
C 40001800 1 1

//--- compile.f
tk_pkg.sv
tk_bus_if.sv
udi_rom.sv
tk_reg_api.sv
tk_sec_monitor.sv
tk_led_ctrl.sv
tk_ctrl_top.sv
tb_tk_ctrl.sv

//--- run_sim.sh
#!/bin/sh
# Compile and run the control core testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
  --top-module tb_tk_ctrl -f compile.f > build.log 2>&1
if [ $? -ne 0 ]; then
  echo "Compile failed, see build.log"
  exit 1
fi

./obj_dir/Vtb_tk_ctrl > sim.log 2>&1
sim_status=$?

if grep -q "Test FAILED" sim.log; then
  echo "Simulation failed, see sim.log"
  exit 1
fi
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status, see sim.log"
  exit 1
fi
echo "Simulation passed"
exit 0
